// File: hdl/ecc_pkg.sv
package ecc_pkg;

    // ####################################################################
    // sizes
    // ####################################################################

    localparam int DATA_WIDTH   = 28;
    localparam int PARITY_WIDTH = 7;
    localparam int CODE_WIDTH   = DATA_WIDTH + PARITY_WIDTH;
    localparam int ADDR_WIDTH   = 6;
    localparam int DEPTH        = 1 << ADDR_WIDTH;
    localparam int COUNT_WIDTH  = 16;

    // data bits feeding each check bit; entry 6 is the overall term.
    localparam logic [DATA_WIDTH-1:0] PARITY_MASK [PARITY_WIDTH] = '{
        28'h6AAAD5B,
        28'hB33366D,
        28'h3C3C78E,
        28'h3FC07F0,
        28'h3FFF800,
        28'hC000000,
        28'hDA65CB7
    };

    // ####################################################################
    // structs
    // ####################################################################

    typedef struct packed {
        logic [ADDR_WIDTH-1:0] addr;
        logic [DATA_WIDTH-1:0] data;
        logic [CODE_WIDTH-1:0] flip;   // bits of the stored word to invert.
    } wr_cmd_t;

    // parity sits on top, so flip bits 28..34 hit the check bits.
    typedef struct packed {
        logic [PARITY_WIDTH-1:0] parity;
        logic [DATA_WIDTH-1:0]   data;
    } code_word_t;

    typedef struct packed {
        logic [DATA_WIDTH-1:0]   data;
        logic [PARITY_WIDTH-1:0] parity;   // as stored.
        logic                    sbit_err;
        logic                    dbit_err;
    } rd_rsp_t;

    typedef struct packed {
        logic [COUNT_WIDTH-1:0] sbit_count;
        logic [COUNT_WIDTH-1:0] dbit_count;
        logic [ADDR_WIDTH-1:0]  last_err_addr;
    } err_status_t;

    // ####################################################################
    // check bit generation
    // ####################################################################

    function automatic logic [PARITY_WIDTH-1:0] ecc_encode(
        input logic [DATA_WIDTH-1:0] d
    );
        logic [PARITY_WIDTH-1:0] p;
        p = '0;
        for (int i = 0; i < PARITY_WIDTH; i++) begin
            p[i] = ^(d & PARITY_MASK[i]);
        end
        return p;
    endfunction

endpackage

// File: hdl/ecc_28_cal.sv
module ecc_28_cal (
    input  logic [ecc_pkg::DATA_WIDTH-1:0]   data_in,
    input  logic [ecc_pkg::PARITY_WIDTH-1:0] parity_in,
    input  logic                             bypass,
    output logic [ecc_pkg::DATA_WIDTH-1:0]   data_out,
    output logic [ecc_pkg::PARITY_WIDTH-1:0] parity_out,
    output logic [ecc_pkg::DATA_WIDTH-1:0]   mask,
    output logic                             sbit_err,
    output logic                             dbit_err
);
    import ecc_pkg::*;

    logic [PARITY_WIDTH-1:0] calc_parity;
    logic [PARITY_WIDTH-1:0] syndrome;
    logic                    chk_only;   // error confined to a check bit.
    logic                    multi;

    assign calc_parity = ecc_encode(data_in);
    assign syndrome    = calc_parity ^ parity_in;

    // syndrome to data bit position.
    always_comb begin
        mask     = '0;
        chk_only = 1'b0;
        multi    = 1'b0;
        case (syndrome)
            7'h00: mask = '0;
            7'h43: mask[0]  = 1'b1;
            7'h45: mask[1]  = 1'b1;
            7'h46: mask[2]  = 1'b1;
            7'h07: mask[3]  = 1'b1;
            7'h49: mask[4]  = 1'b1;
            7'h4A: mask[5]  = 1'b1;
            7'h0B: mask[6]  = 1'b1;
            7'h4C: mask[7]  = 1'b1;
            7'h0D: mask[8]  = 1'b1;
            7'h0E: mask[9]  = 1'b1;
            7'h4F: mask[10] = 1'b1;
            7'h51: mask[11] = 1'b1;
            7'h52: mask[12] = 1'b1;
            7'h13: mask[13] = 1'b1;
            7'h54: mask[14] = 1'b1;
            7'h15: mask[15] = 1'b1;
            7'h16: mask[16] = 1'b1;
            7'h57: mask[17] = 1'b1;
            7'h58: mask[18] = 1'b1;
            7'h19: mask[19] = 1'b1;
            7'h1A: mask[20] = 1'b1;
            7'h5B: mask[21] = 1'b1;
            7'h1C: mask[22] = 1'b1;
            7'h5D: mask[23] = 1'b1;
            7'h5E: mask[24] = 1'b1;
            7'h1F: mask[25] = 1'b1;
            7'h61: mask[26] = 1'b1;
            7'h62: mask[27] = 1'b1;
            // one check bit flipped, data is good.
            7'h01,
            7'h02,
            7'h04,
            7'h08,
            7'h10,
            7'h20,
            7'h40: chk_only = 1'b1;
            default: multi = 1'b1;   // uncorrectable.
        endcase
    end

    assign data_out   = bypass ? data_in : (data_in ^ mask);
    assign parity_out = parity_in;   // stored check bits.
    assign sbit_err   = !bypass && ((|mask) || chk_only);
    assign dbit_err   = !bypass && multi;

endmodule

// File: hdl/ecc_mem_array.sv
module ecc_mem_array (
    input  logic                           clk,
    input  logic                           wr_en,
    input  logic [ecc_pkg::ADDR_WIDTH-1:0] wr_addr,
    input  ecc_pkg::code_word_t            wr_word,
    input  logic                           rd_en,
    input  logic [ecc_pkg::ADDR_WIDTH-1:0] rd_addr,
    output ecc_pkg::code_word_t            rd_word
);
    import ecc_pkg::*;

    code_word_t mem [DEPTH];

    // ####################################################################
    // write port
    // ####################################################################

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_word;
        end
    end

    // ####################################################################
    // read port
    // ####################################################################

    // sampled before the write lands, so a same address read sees old data.
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_word <= mem[rd_addr];
        end
    end

endmodule

// File: hdl/ecc_err_log.sv
module ecc_err_log (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           chk_valid,
    input  logic                           sbit_err,
    input  logic                           dbit_err,
    input  logic [ecc_pkg::ADDR_WIDTH-1:0] chk_addr,
    output ecc_pkg::err_status_t           status
);
    import ecc_pkg::*;

    logic sbit_hit;
    logic dbit_hit;
    logic sbit_full;
    logic dbit_full;

    assign sbit_hit  = chk_valid && sbit_err;
    assign dbit_hit  = chk_valid && dbit_err;
    assign sbit_full = &status.sbit_count;
    assign dbit_full = &status.dbit_count;

    // ####################################################################
    // saturating counters
    // ####################################################################

    always_ff @(posedge clk) begin
        if (reset) begin
            status.sbit_count <= '0;
            status.dbit_count <= '0;
        end else begin
            if (sbit_hit && !sbit_full) begin
                status.sbit_count <= status.sbit_count + 1'b1;
            end
            if (dbit_hit && !dbit_full) begin
                status.dbit_count <= status.dbit_count + 1'b1;
            end
        end
    end

    // most recent failing address.
    always_ff @(posedge clk) begin
        if (reset) begin
            status.last_err_addr <= '0;
        end else if (sbit_hit || dbit_hit) begin
            status.last_err_addr <= chk_addr;
        end
    end

endmodule

// File: hdl/ecc_ram.sv
module ecc_ram (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           wr_en,
    input  ecc_pkg::wr_cmd_t               wr_cmd,
    input  logic                           rd_en,
    input  logic [ecc_pkg::ADDR_WIDTH-1:0] rd_addr,
    input  logic                           bypass,
    output logic                           rd_valid,
    output ecc_pkg::rd_rsp_t               rd_rsp,
    output ecc_pkg::err_status_t           err_status
);
    import ecc_pkg::*;

    logic [PARITY_WIDTH-1:0] wr_parity;
    code_word_t              wr_word;
    code_word_t              rd_word;

    logic                    s1_valid;
    logic [ADDR_WIDTH-1:0]   s1_addr;

    logic [DATA_WIDTH-1:0]   chk_data;
    logic [PARITY_WIDTH-1:0] chk_parity;
    logic                    chk_sbit;
    logic                    chk_dbit;

    // ####################################################################
    // write encode
    // ####################################################################

    assign wr_parity = ecc_encode(wr_cmd.data);
    assign wr_word   = code_word_t'({wr_parity, wr_cmd.data} ^ wr_cmd.flip);   // fault plant.

    ecc_mem_array u_mem (
        .clk     (clk),
        .wr_en   (wr_en),
        .wr_addr (wr_cmd.addr),
        .wr_word (wr_word),
        .rd_en   (rd_en),
        .rd_addr (rd_addr),
        .rd_word (rd_word)
    );

    // ####################################################################
    // read pipeline
    // ####################################################################

    always_ff @(posedge clk) begin
        if (reset) begin
            s1_valid <= 1'b0;
        end else begin
            s1_valid <= rd_en;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_en) begin
            s1_addr <= rd_addr;   // matches the array output.
        end
    end

    ecc_28_cal u_cal (
        .data_in    (rd_word.data),
        .parity_in  (rd_word.parity),
        .bypass     (bypass),
        .data_out   (chk_data),
        .parity_out (chk_parity),
        .mask       (),
        .sbit_err   (chk_sbit),
        .dbit_err   (chk_dbit)
    );

    // response one cycle after the array.
    always_ff @(posedge clk) begin
        if (reset) begin
            rd_valid <= 1'b0;
        end else begin
            rd_valid <= s1_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (s1_valid) begin
            rd_rsp.data     <= chk_data;
            rd_rsp.parity   <= chk_parity;
            rd_rsp.sbit_err <= chk_sbit;
            rd_rsp.dbit_err <= chk_dbit;
        end
    end

    ecc_err_log u_log (
        .clk       (clk),
        .reset     (reset),
        .chk_valid (s1_valid),
        .sbit_err  (chk_sbit),
        .dbit_err  (chk_dbit),
        .chk_addr  (s1_addr),
        .status    (err_status)
    );

endmodule

// File: dv/ecc_ram_tb.sv
module ecc_ram_tb;
    timeunit 1ns;
    timeprecision 100ps;

    import ecc_pkg::*;

    logic                  clk;
    logic                  reset;
    logic                  wr_en;
    wr_cmd_t               wr_cmd;
    logic                  rd_en;
    logic [ADDR_WIDTH-1:0] rd_addr;
    logic                  bypass;
    logic                  rd_valid;
    rd_rsp_t               rd_rsp;
    err_status_t           err_status;

    // stimulus table by row.
    string                 t_name [$];
    logic [ADDR_WIDTH-1:0] t_addr [$];
    logic [DATA_WIDTH-1:0] t_data [$];
    logic [CODE_WIDTH-1:0] t_flip [$];
    logic                  t_bypass [$];
    rd_rsp_t               t_exp [$];

    rd_rsp_t               pend_exp [$];   // burst reads in flight.
    string                 pend_name [$];

    logic [31:0]           rng_state;
    err_status_t           log_exp;
    int                    n_errors;
    int                    n_pass;
    int                    n_fail;
    int                    first_cyc;
    int                    last_cyc;
    bit                    table_ready = 1'b0;

    ecc_ram DUT (
        .clk        (clk),
        .reset      (reset),
        .wr_en      (wr_en),
        .wr_cmd     (wr_cmd),
        .rd_en      (rd_en),
        .rd_addr    (rd_addr),
        .bypass     (bypass),
        .rd_valid   (rd_valid),
        .rd_rsp     (rd_rsp),
        .err_status (err_status)
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;

    // ####################################################################
    // reference model
    // ####################################################################

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [CODE_WIDTH-1:0] bit_at(input int pos);
        logic [CODE_WIDTH-1:0] v;
        v      = '0;
        v[pos] = 1'b1;
        return v;
    endfunction

    // one flip is corrected, two are flagged and left alone.
    function automatic rd_rsp_t predict(
        input logic [DATA_WIDTH-1:0] data,
        input logic [CODE_WIDTH-1:0] flip,
        input logic                  byp
    );
        rd_rsp_t r;
        int      n_flips;
        n_flips    = $countones(flip);
        r.data     = data;
        r.parity   = ecc_encode(data) ^ flip[CODE_WIDTH-1:DATA_WIDTH];
        r.sbit_err = 1'b0;
        r.dbit_err = 1'b0;
        if (byp) begin
            r.data = data ^ flip[DATA_WIDTH-1:0];   // raw word.
        end else if (n_flips == 1) begin
            r.sbit_err = 1'b1;
        end else if (n_flips == 2) begin
            r.data     = data ^ flip[DATA_WIDTH-1:0];
            r.dbit_err = 1'b1;
        end
        return r;
    endfunction

    task automatic add_row(input string name, input logic [CODE_WIDTH-1:0] flip,
                           input logic byp);
        logic [DATA_WIDTH-1:0] d;
        rng_state = xorshift(rng_state);
        d         = rng_state[DATA_WIDTH-1:0];
        t_addr.push_back(ADDR_WIDTH'(t_name.size() * 37));   // odd stride keeps addresses distinct.
        t_name.push_back(name);
        t_data.push_back(d);
        t_flip.push_back(flip);
        t_bypass.push_back(byp);
        t_exp.push_back(predict(d, flip, byp));
    endtask

    task automatic build_table();
        for (int i = 0; i < 4; i++) begin
            add_row($sformatf("clean_%0d", i), '0, 1'b0);
        end
        for (int b = 0; b < DATA_WIDTH; b++) begin
            add_row($sformatf("data_flip_%0d", b), bit_at(b), 1'b0);
        end
        for (int c = 0; c < PARITY_WIDTH; c++) begin
            add_row($sformatf("chk_flip_%0d", c), bit_at(DATA_WIDTH + c), 1'b0);
        end
        add_row("dbl_d0_d1", bit_at(0) | bit_at(1), 1'b0);
        add_row("dbl_d5_d9", bit_at(5) | bit_at(9), 1'b0);
        add_row("dbl_d3_c0", bit_at(3) | bit_at(DATA_WIDTH), 1'b0);
        add_row("dbl_d0_c6", bit_at(0) | bit_at(CODE_WIDTH - 1), 1'b0);
        add_row("byp_d7", bit_at(7), 1'b1);
        add_row("byp_c2", bit_at(DATA_WIDTH + 2), 1'b1);
    endtask

    task automatic expect_log(input int i);
        if (t_exp[i].sbit_err) log_exp.sbit_count++;
        if (t_exp[i].dbit_err) log_exp.dbit_count++;
        if (t_exp[i].sbit_err || t_exp[i].dbit_err) begin
            log_exp.last_err_addr = t_addr[i];
        end
    endtask

    // ####################################################################
    // checks
    // ####################################################################

    task automatic check_rsp(input string name, input rd_rsp_t exp, input rd_rsp_t act);
        if (act !== exp) begin
            $display("MISMATCH %s expected data=%h parity=%h sbit=%b dbit=%b", name,
                     exp.data, exp.parity, exp.sbit_err, exp.dbit_err);
            $display("MISMATCH %s actual   data=%h parity=%h sbit=%b dbit=%b", name,
                     act.data, act.parity, act.sbit_err, act.dbit_err);
            n_errors++;
        end
    endtask

    task automatic check_status(input string name, input err_status_t exp,
                                input err_status_t act);
        if (act !== exp) begin
            $display("MISMATCH %s expected sbit=%0d dbit=%0d last=%0d", name,
                     exp.sbit_count, exp.dbit_count, exp.last_err_addr);
            $display("MISMATCH %s actual   sbit=%0d dbit=%0d last=%0d", name,
                     act.sbit_count, act.dbit_count, act.last_err_addr);
            n_errors++;
        end
    endtask

    task automatic report_test(input string name, input int errs_before);
        if (n_errors == errs_before) begin
            n_pass++;
            $display("test %s: ok", name);
        end else begin
            n_fail++;
            $display("test %s: failed", name);
        end
    endtask

    // ####################################################################
    // stimulus
    // ####################################################################

    task automatic next_cycle();
        @(posedge clk);
        #2;
    endtask

    // rd_valid is due on the first edge after the one that samples rd_en.
    task automatic wait_valid(input string name, output bit seen);
        int n_cycles;
        seen     = 1'b0;
        n_cycles = 0;
        while (!seen && n_cycles < 6) begin
            next_cycle();
            n_cycles++;
            seen = rd_valid;
        end
        if (!seen) begin
            $display("ERROR %s: no read response came back within 6 cycles", name);
            n_errors++;
        end else if (n_cycles != 1) begin
            $display("ERROR %s: read response came back %0d cycles late", name,
                     n_cycles - 1);
            n_errors++;
        end
    endtask

    task automatic apply_row(input int i);
        bit seen;
        int errs_before;
        errs_before = n_errors;
        wr_en       = 1'b1;
        wr_cmd.addr = t_addr[i];
        wr_cmd.data = t_data[i];
        wr_cmd.flip = t_flip[i];
        next_cycle();
        wr_en   = 1'b0;
        wr_cmd  = '0;
        rd_en   = 1'b1;
        rd_addr = t_addr[i];
        bypass  = t_bypass[i];   // held until the response.
        next_cycle();
        rd_en = 1'b0;
        wait_valid(t_name[i], seen);
        expect_log(i);
        if (seen) begin
            check_rsp(t_name[i], t_exp[i], rd_rsp);
            check_status(t_name[i], log_exp, err_status);
        end
        report_test(t_name[i], errs_before);
    endtask

    task automatic take_response(input int cyc);
        if (rd_valid) begin
            if (pend_exp.size() == 0) begin
                $display("ERROR burst: a response arrived with no read outstanding");
                n_errors++;
            end else begin
                check_rsp(pend_name[0], pend_exp[0], rd_rsp);
                void'(pend_exp.pop_front());
                void'(pend_name.pop_front());
            end
            if (first_cyc < 0) first_cyc = cyc;
            last_cyc = cyc;
        end
    endtask

    // rereads every row with bypass low at one read per cycle.
    task automatic read_burst();
        int errs_before;
        int n_reads;
        int cyc;
        int idle;
        errs_before = n_errors;
        n_reads     = 0;
        cyc         = 0;
        idle        = 0;
        first_cyc   = -1;
        last_cyc    = -1;
        bypass      = 1'b0;
        for (int i = 0; i < t_name.size(); i++) begin
            if (!t_bypass[i]) begin
                rd_en   = 1'b1;
                rd_addr = t_addr[i];
                pend_exp.push_back(t_exp[i]);
                pend_name.push_back(t_name[i]);
                expect_log(i);
                n_reads++;
                next_cycle();
                cyc++;
                take_response(cyc);
            end
        end
        rd_en = 1'b0;
        while (pend_exp.size() > 0 && idle < 6) begin
            next_cycle();
            cyc++;
            idle = rd_valid ? 0 : idle + 1;
            take_response(cyc);
        end
        if (pend_exp.size() != 0) begin
            $display("ERROR burst: %0d reads never returned", pend_exp.size());
            n_errors++;
        end else if (last_cyc - first_cyc != n_reads - 1) begin
            $display("ERROR burst: responses did not arrive one per cycle");
            n_errors++;
        end
        report_test("burst", errs_before);
    endtask

    // ####################################################################
    // main sequence and watchdog
    // ####################################################################

    initial begin
        int errs_before;
        reset     = 1'b1;
        wr_en     = 1'b0;
        wr_cmd    = '0;
        rd_en     = 1'b0;
        rd_addr   = '0;
        bypass    = 1'b0;
        n_errors  = 0;
        n_pass    = 0;
        n_fail    = 0;
        log_exp   = '0;
        rng_state = 32'h725c;
        build_table();
        table_ready = 1'b1;
        repeat (16) @(posedge clk);
        #2;
        reset       = 1'b0;
        errs_before = n_errors;
        if (rd_valid !== 1'b0) begin
            $display("ERROR reset: rd_valid is not low after reset");
            n_errors++;
        end
        check_status("reset", '0, err_status);
        report_test("reset", errs_before);
        for (int i = 0; i < t_name.size(); i++) begin
            apply_row(i);
        end
        errs_before = n_errors;
        check_status("log_after_table", log_exp, err_status);
        report_test("log_after_table", errs_before);
        read_burst();
        errs_before = n_errors;
        check_status("log_after_burst", log_exp, err_status);
        report_test("log_after_burst", errs_before);
        $display("summary: %0d tests passed, %0d failed, %0d errors", n_pass, n_fail, n_errors);
        if (n_fail == 0 && n_errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

    initial begin
        wait (table_ready);
        repeat (t_name.size() * 8 + 100) @(posedge clk);
        $display("ERROR watchdog: the run did not finish in time");
        $display("=== FAIL ===");
        $finish;
    end

endmodule

// File: verilog.f
hdl/ecc_pkg.sv
hdl/ecc_28_cal.sv
hdl/ecc_mem_array.sv
hdl/ecc_err_log.sv
hdl/ecc_ram.sv
dv/ecc_ram_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the ecc_ram testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal \
    --top-module ecc_ram_tb \
    -f verilog.f \
    -o ecc_ram_sim
if [ $? -ne 0 ]; then
    echo "run.sh: compile failed"
    exit 1
fi

out=$(./obj_dir/ecc_ram_sim)
status=$?
printf '%s\n' "$out"

if [ $status -ne 0 ]; then
    echo "run.sh: simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qx "=== PASS ==="; then
    echo "run.sh: simulation passed"
    exit 0
fi

echo "run.sh: simulation failed"
exit 1
